/* Bender.yml */
package:
  name: dcp

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/dcp_char_pkg.sv
      - common/dcp_data_pkg.sv
      - dcp/dcp_scan.sv
      - dcp/dcp_print.sv
      - dcp/dcp_cmd_ctrl.sv
      - verilog/dcp_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_dcp.sv

/* common/dcp_char_pkg.sv */
`default_nettype none
`include "dcp_config.svh"

package dcp_char_pkg;

    // one console byte
    typedef logic [`DCP_CHAR_W-1:0] char_t;

    // command letters, upper case ascii codes
    typedef enum logic [`DCP_CHAR_W-1:0] {
        CMD_P = 8'h50,
        CMD_D = 8'h44,
        CMD_I = 8'h49
    } cmd_letter_e;

    // line end, separator, error reply
    localparam char_t CH_NL = 8'h0a;
    localparam char_t CH_SP = 8'h20;
    localparam char_t CH_QM = 8'h3f;

    // hex digit ranges
    localparam char_t CH_0  = 8'h30;
    localparam char_t CH_9  = 8'h39;
    localparam char_t CH_LA = 8'h61;
    localparam char_t CH_LF = 8'h66;
    localparam char_t CH_UA = 8'h41;
    localparam char_t CH_UF = 8'h46;

endpackage

`default_nettype wire

/* common/dcp_config.svh */
`ifndef DCP_CONFIG_SVH
`define DCP_CONFIG_SVH

// widths of the debug panel
// all of them fixed by the teaching processor

// data word, instruction word and pc
`define DCP_WORD_W 32

// address bus shared by both memories
`define DCP_ADDR_W 32

// one console byte, plain ascii
`define DCP_CHAR_W 8

// hex digits in one printed word
// one digit per nibble of DCP_WORD_W
`define DCP_HEX_DIGITS 8

`endif

/* common/dcp_data_pkg.sv */
`default_nettype none
`include "dcp_config.svh"

package dcp_data_pkg;

    // memory word, pc
    typedef logic [`DCP_WORD_W-1:0] word_t;
    // memory address
    typedef logic [`DCP_ADDR_W-1:0] addr_t;

    // what the receive engine reads
    typedef enum logic {
        SCAN_CHAR = 1'b0,
        SCAN_HEX  = 1'b1
    } scan_kind_e;

    // what the transmit engine sends
    typedef enum logic {
        PRINT_CHAR = 1'b0,
        PRINT_WORD = 1'b1
    } print_kind_e;

    // controller to scanner, req held until ack
    typedef struct packed {
        logic       req;
        scan_kind_e kind;
    } scan_req_t;

    // scanner answer, valid while ack is high
    typedef struct packed {
        logic  ack;
        logic  eol;
        word_t value;
    } scan_rsp_t;

    // controller to printer
    typedef struct packed {
        logic        req;
        print_kind_e kind;
        word_t       value;
    } print_req_t;

endpackage

`default_nettype wire

/* dcp/dcp_cmd_ctrl.sv */
`default_nettype none
`include "dcp_config.svh"

module dcp_cmd_ctrl
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    output dcp_data_pkg::scan_req_t      scan_req,
    input  wire dcp_data_pkg::scan_rsp_t scan_rsp,
    output dcp_data_pkg::print_req_t     print_req,
    input  wire logic                    ack_tx,
    input  wire dcp_data_pkg::word_t     pc,
    input  wire dcp_data_pkg::word_t     dout_dm,
    input  wire dcp_data_pkg::word_t     dout_im,
    output dcp_data_pkg::addr_t          addr
);

    import dcp_char_pkg::*;
    import dcp_data_pkg::*;

    // ST_DONE sends the newline after an error reply
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_ARG,
        ST_DRAIN,
        ST_PRINT,
        ST_DONE
    } state_e;

    state_e      state;
    cmd_letter_e letter;
    char_t       rx_char;
    logic        has_arg;
    logic        known;

    assign rx_char = scan_rsp.value[`DCP_CHAR_W-1:0];
    // D and I take an address token
    assign has_arg = (rx_char == CMD_D) || (rx_char == CMD_I);

    //////////////////////////////
    // command sequencing, address latch
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= ST_FETCH;
            letter <= CMD_P;
            addr   <= '0;
        end
        else
        begin
            case (state)
                ST_FETCH:
                begin
                    if (scan_rsp.ack)
                    begin
                        letter <= cmd_letter_e'(rx_char);
                        if (has_arg)
                            state <= ST_ARG;
                        // bare newline gets its reply at once
                        else if (scan_rsp.eol)
                            state <= ST_PRINT;
                        else
                            state <= ST_DRAIN;
                    end
                end
                ST_ARG:
                begin
                    if (scan_rsp.ack)
                    begin
                        addr <= addr_t'(scan_rsp.value);
                        if (scan_rsp.eol)
                            state <= ST_PRINT;
                        else
                            state <= ST_DRAIN;
                    end
                end
                // eat the rest of the line
                ST_DRAIN:
                begin
                    if (scan_rsp.ack && scan_rsp.eol)
                        state <= ST_PRINT;
                end
                ST_PRINT:
                begin
                    if (ack_tx)
                        state <= known ? ST_FETCH : ST_DONE;
                end
                default:
                begin
                    if (ack_tx)
                        state <= ST_FETCH;
                end
            endcase
        end
    end

    // scanner requests
    always_comb
    begin
        scan_req.req  = (state == ST_FETCH) || (state == ST_ARG) || (state == ST_DRAIN);
        scan_req.kind = (state == ST_ARG) ? SCAN_HEX : SCAN_CHAR;
    end

    //////////////////////////////
    // reply selection
    always_comb
    begin
        print_req.req   = (state == ST_PRINT) || (state == ST_DONE);
        print_req.kind  = PRINT_WORD;
        print_req.value = '0;
        known           = 1'b1;
        case (letter)
            CMD_P: print_req.value = pc;
            CMD_D: print_req.value = dout_dm;
            CMD_I: print_req.value = dout_im;
            default:
            begin
                known           = 1'b0;
                print_req.kind  = PRINT_CHAR;
                print_req.value = word_t'(CH_QM);
            end
        endcase
        if (state == ST_DONE)
        begin
            print_req.kind  = PRINT_CHAR;
            print_req.value = word_t'(CH_NL);
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) !$isunknown(state));

endmodule

`default_nettype wire

/* dcp/dcp_print.sv */
`default_nettype none
`include "dcp_config.svh"

module dcp_print
(
    input  wire logic                     clk,
    input  wire logic                     rstn,
    input  wire dcp_data_pkg::print_req_t print_req,
    output logic                          ack_tx,
    output dcp_char_pkg::char_t           d_tx,
    output logic                          vld_tx,
    input  wire logic                     rdy_tx
);

    import dcp_char_pkg::*;
    import dcp_data_pkg::*;

    typedef enum logic [1:0] {
        PR_IDLE,
        PR_SEND,
        PR_ACK
    } pr_state_e;

    // counts digits, final value selects the newline
    localparam int CNT_W = $clog2(`DCP_HEX_DIGITS + 1);

    pr_state_e        state;
    print_kind_e      kind_q;
    word_t            shift_q;
    logic [CNT_W-1:0] cnt_q;
    logic [3:0]       nib;
    logic             nl_slot;
    logic             last;

    assign nib     = shift_q[`DCP_WORD_W-1 -: 4];
    assign nl_slot = (cnt_q == CNT_W'(`DCP_HEX_DIGITS));
    assign last    = (kind_q == PRINT_CHAR) || nl_slot;
    assign vld_tx  = (state == PR_SEND);
    assign ack_tx  = (state == PR_ACK);

    //////////////////////////////
    // outgoing byte
    always_comb
    begin
        if (kind_q == PRINT_CHAR)
            d_tx = shift_q[`DCP_CHAR_W-1:0];
        else if (nl_slot)
            d_tx = CH_NL;
        else if (nib < 4'd10)
            d_tx = CH_0 + char_t'(nib);
        else
            d_tx = CH_LA + char_t'(nib) - 8'd10;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= PR_IDLE;
            kind_q <= PRINT_CHAR;
            cnt_q  <= '0;
        end
        else
        begin
            case (state)
                PR_IDLE:
                begin
                    if (print_req.req)
                    begin
                        kind_q <= print_req.kind;
                        cnt_q  <= '0;
                        state  <= PR_SEND;
                    end
                end
                PR_SEND:
                begin
                    // everything holds while the console stalls
                    if (rdy_tx)
                    begin
                        if (last)
                            state <= PR_ACK;
                        else
                            cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state <= PR_IDLE;
            endcase
        end
    end

    // word being printed, top nibble first
    always_ff @(posedge clk)
    begin
        if (state == PR_IDLE && print_req.req)
            shift_q <= print_req.value;
        else if (state == PR_SEND && rdy_tx && !last)
            shift_q <= shift_q << 4;
    end

    // console sees a steady byte under back-pressure
    assert property (@(posedge clk) disable iff (!rstn)
        vld_tx && !rdy_tx |=> vld_tx && $stable(d_tx));

endmodule

`default_nettype wire

/* dcp/dcp_scan.sv */
`default_nettype none
`include "dcp_config.svh"

module dcp_scan
(
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire dcp_char_pkg::char_t     d_rx,
    input  wire logic                    vld_rx,
    output logic                         rdy_rx,
    input  wire dcp_data_pkg::scan_req_t scan_req,
    output dcp_data_pkg::scan_rsp_t      scan_rsp
);

    import dcp_char_pkg::*;
    import dcp_data_pkg::*;

    typedef enum logic [1:0] {
        SC_IDLE,
        SC_RECV,
        SC_ACK
    } sc_state_e;

    sc_state_e  state;
    // some hex digit already shifted in
    logic       seen_q;
    logic       eol_q;
    word_t      acc_q;
    logic       take;
    logic       is_hex;
    logic [3:0] nib;

    // only open for bytes while a request is being served
    assign rdy_rx = (state == SC_RECV);
    assign take   = rdy_rx & vld_rx;

    assign scan_rsp = '{ack: (state == SC_ACK), eol: eol_q, value: acc_q};

    //////////////////////////////
    // ascii hex digit to nibble
    always_comb
    begin
        is_hex = 1'b1;
        nib    = 4'h0;
        if (d_rx >= CH_0 && d_rx <= CH_9)
            nib = 4'(d_rx - CH_0);
        else if (d_rx >= CH_LA && d_rx <= CH_LF)
            nib = 4'(d_rx - CH_LA + 8'd10);
        else if (d_rx >= CH_UA && d_rx <= CH_UF)
            nib = 4'(d_rx - CH_UA + 8'd10);
        else
            is_hex = 1'b0;
    end

    //////////////////////////////
    // request sequencing
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state  <= SC_IDLE;
            seen_q <= 1'b0;
            eol_q  <= 1'b0;
            acc_q  <= '0;
        end
        else
        begin
            case (state)
                SC_IDLE:
                begin
                    // fresh item, clear the accumulator
                    if (scan_req.req)
                    begin
                        seen_q <= 1'b0;
                        eol_q  <= 1'b0;
                        acc_q  <= '0;
                        state  <= SC_RECV;
                    end
                end
                SC_RECV:
                begin
                    if (take)
                    begin
                        if (scan_req.kind == SCAN_CHAR)
                        begin
                            acc_q <= {{(`DCP_WORD_W-`DCP_CHAR_W){1'b0}}, d_rx};
                            eol_q <= (d_rx == CH_NL);
                            state <= SC_ACK;
                        end
                        else if (is_hex)
                        begin
                            acc_q  <= {acc_q[`DCP_WORD_W-5:0], nib};
                            seen_q <= 1'b1;
                        end
                        // leading blanks skipped, anything else ends the token
                        else if (!(d_rx == CH_SP && !seen_q))
                        begin
                            eol_q <= (d_rx == CH_NL);
                            state <= SC_ACK;
                        end
                    end
                end
                // ack cycle, back to idle
                default: state <= SC_IDLE;
            endcase
        end
    end

    // controller must still hold its request when the answer comes
    assert property (@(posedge clk) disable iff (!rstn) scan_rsp.ack |-> scan_req.req);
    // no byte is taken from the console unless asked for
    assert property (@(posedge clk) disable iff (!rstn) !scan_req.req |-> !rdy_rx);

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/dcp_char_pkg.sv
common/dcp_data_pkg.sv
dcp/dcp_scan.sv
dcp/dcp_print.sv
dcp/dcp_cmd_ctrl.sv
verilog/dcp_top.sv
tests/tb_dcp.sv

/* tests/tb_dcp.sv */
`default_nettype none
`include "dcp_config.svh"

module tb_dcp;

    timeunit 1ns;
    timeprecision 1ps;

    import dcp_char_pkg::*;
    import dcp_data_pkg::*;

    localparam int  CLK_PERIOD = 20;
    localparam int  NUM_TESTS  = 6;
    // memory model keys
    localparam word_t DM_KEY   = 32'h5a3c_96e1;
    localparam word_t IM_KEY   = 32'h1000_0000;

    logic  clk;
    logic  rstn;
    char_t d_rx;
    logic  vld_rx;
    logic  rdy_rx;
    char_t d_tx;
    logic  vld_tx;
    logic  rdy_tx;
    word_t pc;
    addr_t addr;
    word_t dout_dm;
    word_t dout_im;

    // bytes seen on the console output
    byte   rx_q[$];
    byte   ref_q[$];
    int    err_count;

    // combinational memories, pattern over the full address
    assign dout_dm = addr ^ DM_KEY;
    assign dout_im = addr + IM_KEY;

    dcp_top dut0
    (
        .clk     (clk),
        .rstn    (rstn),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .pc      (pc),
        .addr    (addr),
        .dout_dm (dout_dm),
        .dout_im (dout_im)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // helpers
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected)
        begin
            err_count++;
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "first error, stopping");
        end
    endtask

    // eight lower case digits then a newline
    function automatic string word_reply(input word_t w);
        return $sformatf("%08h\n", w);
    endfunction

    // one byte per accepted rdy_rx, no gap when the scanner keeps up
    task automatic send_line(input string line);
        @(posedge clk);
        for (int i = 0; i < line.len(); i++)
        begin
            d_rx   <= line[i];
            vld_rx <= 1'b1;
            do
                @(negedge clk);
            while (!rdy_rx);
            @(posedge clk);
        end
        vld_rx <= 1'b0;
    endtask

    // bp set means random stalls on rdy_tx
    task automatic collect_reply(input int n, input bit bp);
        rx_q.delete();
        while (rx_q.size() < n)
        begin
            @(posedge clk);
            rdy_tx <= bp ? 1'($urandom % 2) : 1'b1;
            @(negedge clk);
            if (vld_tx && rdy_tx)
                rx_q.push_back(d_tx);
        end
        @(posedge clk);
        rdy_tx <= 1'b0;
    endtask

    task automatic expect_reply(input string exp, input bit bp, input string msg);
        collect_reply(exp.len(), bp);
        for (int i = 0; i < exp.len(); i++)
            check(rx_q[i], exp[i], $sformatf("%s byte %0d", msg, i));
    endtask

    //////////////////////////////
    // directed tests
    task automatic test_reset();
        rstn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check(vld_tx, 1'b0, "vld_tx in reset");
        check(rdy_rx, 1'b0, "rdy_rx in reset");
        check(addr, 32'h0, "addr in reset");
        @(posedge clk);
        rstn <= 1'b1;
    endtask

    task automatic test_print_pc();
        send_line("P\n");
        expect_reply(word_reply(pc), 1'b0, "pc reply");
    endtask

    task automatic test_dump_data();
        send_line("D 1a0\n");
        expect_reply(word_reply(32'h1a0 ^ DM_KEY), 1'b0, "data word");
        check(addr, 32'h1a0, "addr after D");
        // upper case digits, extra blanks around the token
        send_line("D   1A0 \n");
        expect_reply(word_reply(32'h1a0 ^ DM_KEY), 1'b0, "data word, upper case");
        check(addr, 32'h1a0, "addr after upper case D");
    endtask

    task automatic test_dump_instr();
        send_line("I 40\n");
        expect_reply(word_reply(32'h40 + IM_KEY), 1'b0, "instruction word");
        check(addr, 32'h40, "addr after I");
    endtask

    task automatic test_unknown_cmd();
        send_line("X foo 12\n");
        expect_reply("?\n", 1'b0, "unknown command");
        // panel must still answer afterwards
        @(posedge clk);
        pc <= 32'h0bad_f00d;
        send_line("P\n");
        expect_reply(word_reply(32'h0bad_f00d), 1'b0, "pc after unknown");
    endtask

    task automatic test_backpressure();
        send_line("D 7ff0\n");
        collect_reply(9, 1'b0);
        ref_q = rx_q;
        send_line("D 7ff0\n");
        expect_reply(word_reply(32'h7ff0 ^ DM_KEY), 1'b1, "stalled data word");
        for (int i = 0; i < ref_q.size(); i++)
            check(rx_q[i], ref_q[i], $sformatf("stalled vs free byte %0d", i));
    endtask

    //////////////////////////////
    // main sequence
    initial
    begin
        clk       = 1'b0;
        rstn      = 1'b0;
        d_rx      = '0;
        vld_rx    = 1'b0;
        rdy_tx    = 1'b0;
        pc        = 32'h3a5f_00c4;
        err_count = 0;
        void'($urandom(93240));

        test_reset();
        test_print_pc();
        test_dump_data();
        test_dump_instr();
        test_unknown_cmd();
        test_backpressure();

        if (err_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // run bound from the test count
    initial
    begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d cycles", NUM_TESTS * 2000);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* verilog/dcp_top.sv */
`default_nettype none

module dcp_top
(
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire dcp_char_pkg::char_t d_rx,
    input  wire logic                vld_rx,
    output logic                     rdy_rx,
    output dcp_char_pkg::char_t      d_tx,
    output logic                     vld_tx,
    input  wire logic                rdy_tx,
    input  wire dcp_data_pkg::word_t pc,
    output dcp_data_pkg::addr_t      addr,
    input  wire dcp_data_pkg::word_t dout_dm,
    input  wire dcp_data_pkg::word_t dout_im
);

    import dcp_data_pkg::*;

    // controller to engines
    scan_req_t  scan_req;
    scan_rsp_t  scan_rsp;
    print_req_t print_req;
    logic       ack_tx;

    //////////////////////////////
    // command controller
    dcp_cmd_ctrl u_ctrl
    (
        .clk       (clk),
        .rstn      (rstn),
        .scan_req  (scan_req),
        .scan_rsp  (scan_rsp),
        .print_req (print_req),
        .ack_tx    (ack_tx),
        .pc        (pc),
        .dout_dm   (dout_dm),
        .dout_im   (dout_im),
        .addr      (addr)
    );

    // console receive side
    dcp_scan u_scan
    (
        .clk      (clk),
        .rstn     (rstn),
        .d_rx     (d_rx),
        .vld_rx   (vld_rx),
        .rdy_rx   (rdy_rx),
        .scan_req (scan_req),
        .scan_rsp (scan_rsp)
    );

    // console transmit side
    dcp_print u_print
    (
        .clk       (clk),
        .rstn      (rstn),
        .print_req (print_req),
        .ack_tx    (ack_tx),
        .d_tx      (d_tx),
        .vld_tx    (vld_tx),
        .rdy_tx    (rdy_tx)
    );

endmodule

`default_nettype wire
